// File: tb.f
+incdir+logic
logic/snd_pkg.sv
logic/snd_bus_ctrl.sv
logic/snd_regfile.sv
logic/snd_tick_div.sv
logic/snd_pulse.sv
logic/snd_noise.sv
logic/snd_mixer.sv
logic/snd_top.sv
sim/snd_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f --top-module snd_tb \
  && ./obj_dir/Vsnd_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^ALL TESTS PASSED$" sim.log && echo "run_sim: pass" || { echo "run_sim: fail"; exit 1; }

// File: sim/snd_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "snd_defs.svh"

module snd_tb;

  localparam int CLK_PERIOD_NS = 20;
  localparam int NOISE_RUNS = 24;
  localparam int IDLE_SAMPLES = 64;
  localparam int PULSE_SAMPLES_MAX = 200;
  localparam int PAIR_SAMPLES_MAX = 176;
  localparam int NOISE_SAMPLES_MAX = (16 + NOISE_RUNS) * 32;
  localparam int TOTAL_SAMPLES = IDLE_SAMPLES + PULSE_SAMPLES_MAX + PAIR_SAMPLES_MAX
                               + 2 * NOISE_SAMPLES_MAX;
  localparam longint WATCHDOG_NS = longint'(TOTAL_SAMPLES) * `SND_TICK_DIV * CLK_PERIOD_NS * 2;

  logic                   clk_i;
  logic                   rst_i;
  logic                   req_i;
  snd_pkg::bus_req_t      host_req_i;
  logic                   ack_o;
  logic [`SND_DATA_W-1:0] rdata_o;
  snd_pkg::sample_t       sample_o;
  logic                   sample_valid_o;

  snd_pkg::sample_t samples[$];
  int               error_count;

  snd_top i_dut (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .req_i          (req_i),
    .host_req_i     (host_req_i),
    .ack_o          (ack_o),
    .rdata_o        (rdata_o),
    .sample_o       (sample_o),
    .sample_valid_o (sample_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;
  end

  // sample monitor, read away from the rising edge
  always @(negedge clk_i) begin
    if (sample_valid_o) begin
      samples.push_back(sample_o);
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: no result after %0d ns, a handshake or the sample stream stalled",
             WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [`SND_LFSR_W-1:0] ref_lfsr_next(
    input logic [`SND_LFSR_W-1:0] state,
    input logic                   mode
  );
    logic tap;
    tap = mode ? state[6] : state[1];
    return {state[0] ^ tap, state[`SND_LFSR_W-1:1]};
  endfunction

  function automatic snd_pkg::sample_t ref_sample(
    input logic [`SND_LEVEL_W-1:0] p1,
    input logic [`SND_LEVEL_W-1:0] p2,
    input logic [`SND_LEVEL_W-1:0] nz
  );
    snd_pkg::sample_t s;
    int               sum;
    sum = (int'(p1) + int'(p2)) * `SND_PULSE_GAIN + int'(nz) * `SND_NOISE_GAIN;
    s.value = sum[`SND_SAMPLE_W-1:0];
    return s;
  endfunction

  task automatic check_byte(
    input string                  name,
    input logic [`SND_DATA_W-1:0] got,
    input logic [`SND_DATA_W-1:0] exp
  );
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s: got 0x%02h expected 0x%02h", name, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "read data mismatch");
    end
  endtask

  task automatic check_sample(
    input string            name,
    input snd_pkg::sample_t got,
    input snd_pkg::sample_t exp
  );
    if (got !== exp) begin
      error_count++;
      $display("FAILED %s: got 0x%04h expected 0x%04h", name, got.value, exp.value);
      $display("SOME TESTS FAILED");
      $fatal(1, "sample mismatch");
    end
  endtask

  task automatic stop_with_error(input string what);
    error_count++;
    $display("%s", what);
    $display("SOME TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  // four-phase req/ack, paced by ack only
  task automatic bus_handshake(
    input  snd_pkg::bus_req_t      req,
    output logic [`SND_DATA_W-1:0] rdata
  );
    if (ack_o !== 1'b0) begin
      stop_with_error("bus: ack still high when a new request starts");
    end
    @(posedge clk_i);
    req_i      <= 1'b1;
    host_req_i <= req;
    do begin
      @(negedge clk_i);
    end while (ack_o !== 1'b1);
    rdata = rdata_o;
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    if (ack_o !== 1'b1) begin
      stop_with_error("bus: ack dropped before the host released req");
    end
    do begin
      @(negedge clk_i);
    end while (ack_o !== 1'b0);
  endtask

  task automatic bus_write(input logic [`SND_ADDR_W-1:0] addr, input logic [7:0] data);
    snd_pkg::bus_req_t      r;
    logic [`SND_DATA_W-1:0] unused;
    r.wr    = 1'b1;
    r.addr  = addr;
    r.wdata = data;
    bus_handshake(r, unused);
  endtask

  task automatic bus_read(input logic [`SND_ADDR_W-1:0] addr, output logic [7:0] data);
    snd_pkg::bus_req_t r;
    r.wr    = 1'b0;
    r.addr  = addr;
    r.wdata = '0;
    bus_handshake(r, data);
  endtask

  task automatic collect_samples(input int n);
    @(posedge clk_i);
    samples.delete();
    while (samples.size() < n) begin
      @(negedge clk_i);
    end
  endtask

  task automatic test_register_readback();
    logic [7:0] data [`SND_NUM_REGS];
    logic [7:0] got;
    for (int i = 0; i < `SND_NUM_REGS; i++) begin
      data[i] = 8'($urandom);
      bus_write(3'(i), data[i]);
    end
    for (int i = 0; i < `SND_NUM_REGS; i++) begin
      bus_read(3'(i), got);
      check_byte("rdata_o", got, data[i]);
    end
  endtask

  task automatic test_silence();
    snd_pkg::sample_t zero;
    // enables first so the voices fall quiet early
    bus_write(3'd7, 8'h00);
    for (int i = 0; i < 7; i++) begin
      bus_write(3'(i), 8'h00);
    end
    zero = ref_sample(4'd0, 4'd0, 4'd0);
    collect_samples(IDLE_SAMPLES);
    foreach (samples[i]) begin
      check_sample("sample_o", samples[i], zero);
    end
  endtask

  task automatic test_pulse_square();
    logic [3:0]       vol;
    int               period;
    int               n;
    int               first;
    int               run_len;
    int               full_runs;
    snd_pkg::sample_t lo;
    snd_pkg::sample_t hi;
    vol    = 4'($urandom_range(15, 1));
    period = $urandom_range(7, 0);
    bus_write(3'd0, {2'd2, 2'b00, vol});
    bus_write(3'd1, 8'(period));
    bus_write(3'd2, 8'h00);
    bus_write(3'd7, 8'h01);
    lo = ref_sample(4'd0, 4'd0, 4'd0);
    hi = ref_sample(vol, 4'd0, 4'd0);
    n  = 24 * (period + 1) + 8;
    collect_samples(n);
    foreach (samples[i]) begin
      check_sample("sample_o", samples[i], (samples[i] == lo) ? lo : hi);
    end
    first = 0;
    for (int i = n - 1; i > 0; i--) begin
      if (samples[i] != samples[0]) begin
        first = i;
      end
    end
    if (first == 0) begin
      stop_with_error("pulse 1: output never changed level");
    end
    // duty 2 gives equal high and low halves
    run_len   = 1;
    full_runs = 0;
    for (int i = first + 1; i < n; i++) begin
      if (samples[i] == samples[i-1]) begin
        run_len++;
      end else begin
        if (run_len != 4 * (period + 1)) begin
          stop_with_error($sformatf("FAILED sample_o run length: got 0x%0h expected 0x%0h",
                                    run_len, 4 * (period + 1)));
        end
        full_runs++;
        run_len = 1;
      end
    end
    if (full_runs < 2) begin
      stop_with_error("pulse 1: too few complete duty halves in the sample window");
    end
    bus_write(3'd7, 8'h00);
  endtask

  task automatic test_pulse_pair();
    logic [3:0]       v1;
    logic [3:0]       v2;
    int               p1;
    int               n;
    snd_pkg::sample_t combos [4];
    bit               seen [4];
    snd_pkg::sample_t exp;
    v1 = 4'($urandom_range(15, 1));
    v2 = 4'($urandom_range(15, 1));
    // periods one apart so the two phases drift through every overlap
    p1 = $urandom_range(3, 1);
    bus_write(3'd0, {2'd0, 2'b00, v1});
    bus_write(3'd1, 8'(p1));
    bus_write(3'd2, 8'h00);
    bus_write(3'd3, {2'd3, 2'b00, v2});
    bus_write(3'd4, 8'(p1 + 1));
    bus_write(3'd5, 8'h00);
    bus_write(3'd7, 8'h03);
    combos[0] = ref_sample(4'd0, 4'd0, 4'd0);
    combos[1] = ref_sample(v1, 4'd0, 4'd0);
    combos[2] = ref_sample(4'd0, v2, 4'd0);
    combos[3] = ref_sample(v1, v2, 4'd0);
    for (int m = 0; m < 4; m++) begin
      seen[m] = 1'b0;
    end
    n = 8 * (p1 + 1) * (p1 + 2) + 16;
    collect_samples(n);
    foreach (samples[i]) begin
      exp = combos[3];
      for (int m = 0; m < 4; m++) begin
        if (samples[i] == combos[m]) begin
          exp     = combos[m];
          seen[m] = 1'b1;
        end
      end
      check_sample("sample_o", samples[i], exp);
    end
    for (int m = 1; m < 4; m++) begin
      if (!seen[m]) begin
        stop_with_error($sformatf("pulse pair: level combination %0d never appeared", m));
      end
    end
    bus_write(3'd7, 8'h00);
  endtask

  task automatic test_noise(input logic mode);
    logic [`SND_LFSR_W-1:0] lfsr;
    logic [2:0]             code;
    logic [3:0]             vol;
    int                     k0;
    int                     run;
    int                     n;
    int                     first;
    snd_pkg::sample_t       zero;
    snd_pkg::sample_t       exp;
    code = 3'($urandom_range(1, 0));
    vol  = 4'($urandom_range(15, 1));
    run  = int'(code) * 16 + 16;
    bus_write(3'd6, {mode, code, vol});
    bus_write(3'd7, 8'h04);
    // first LFSR step with bit 0 set
    lfsr = `SND_LFSR_SEED;
    k0   = 0;
    do begin
      lfsr = ref_lfsr_next(lfsr, mode);
      k0++;
    end while (!lfsr[0]);
    zero = ref_sample(4'd0, 4'd0, 4'd0);
    n    = (k0 + NOISE_RUNS) * run;
    collect_samples(n);
    first = -1;
    foreach (samples[i]) begin
      if (first < 0 && samples[i] != zero) begin
        first = i;
      end
    end
    if (first < 0) begin
      stop_with_error("noise: output stayed at zero");
    end
    if (first > (k0 - 1) * run || first < (k0 - 2) * run) begin
      stop_with_error($sformatf("noise: sequence starts at sample %0d, out of step", first));
    end
    for (int j = 0; j < NOISE_RUNS; j++) begin
      exp = lfsr[0] ? ref_sample(4'd0, 4'd0, vol) : zero;
      for (int s = 0; s < run; s++) begin
        check_sample("sample_o", samples[first + j * run + s], exp);
      end
      lfsr = ref_lfsr_next(lfsr, mode);
    end
    bus_write(3'd7, 8'h00);
  endtask

  initial begin
    void'($urandom(78071));
    error_count = 0;
    rst_i       = 1'b1;
    req_i       = 1'b0;
    host_req_i  = '0;
    repeat (5) @(posedge clk_i);
    rst_i <= 1'b0;
    test_register_readback();
    test_silence();
    test_pulse_square();
    test_pulse_pair();
    test_noise(1'b0);
    test_noise(1'b1);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/snd_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "snd_defs.svh"

module snd_top (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     req_i,
  input  snd_pkg::bus_req_t       host_req_i,
  output logic                    ack_o,
  output logic [`SND_DATA_W-1:0]  rdata_o,
  output snd_pkg::sample_t        sample_o,
  output logic                    sample_valid_o
);

  logic                    reg_access;
  snd_pkg::bus_req_t       reg_req;
  snd_pkg::pulse_cfg_t     pulse1_cfg;
  snd_pkg::pulse_cfg_t     pulse2_cfg;
  snd_pkg::noise_cfg_t     noise_cfg;
  logic                    snd_tick;
  logic [`SND_LEVEL_W-1:0] pulse1_level;
  logic [`SND_LEVEL_W-1:0] pulse2_level;
  logic [`SND_LEVEL_W-1:0] noise_level;

  snd_bus_ctrl i_bus_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .host_req_i   (host_req_i),
    .ack_o        (ack_o),
    .access_o     (reg_access),
    .access_req_o (reg_req)
  );

  snd_regfile i_regfile (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .access_i     (reg_access),
    .access_req_i (reg_req),
    .rdata_o      (rdata_o),
    .pulse1_cfg_o (pulse1_cfg),
    .pulse2_cfg_o (pulse2_cfg),
    .noise_cfg_o  (noise_cfg)
  );

  snd_tick_div i_tick_div (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .tick_o (snd_tick)
  );

  snd_pulse i_pulse1 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .tick_i  (snd_tick),
    .cfg_i   (pulse1_cfg),
    .level_o (pulse1_level)
  );

  snd_pulse i_pulse2 (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .tick_i  (snd_tick),
    .cfg_i   (pulse2_cfg),
    .level_o (pulse2_level)
  );

  snd_noise i_noise (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .tick_i  (snd_tick),
    .cfg_i   (noise_cfg),
    .level_o (noise_level)
  );

  snd_mixer i_mixer (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .tick_i         (snd_tick),
    .pulse1_level_i (pulse1_level),
    .pulse2_level_i (pulse2_level),
    .noise_level_i  (noise_level),
    .sample_o       (sample_o),
    .sample_valid_o (sample_valid_o)
  );

endmodule

`default_nettype wire

// File: logic/snd_mixer.sv
`timescale 1ns/100ps
`default_nettype none

`include "snd_defs.svh"

module snd_mixer (
  input  wire                    clk_i,
  input  wire                    rst_i,
  input  wire                    tick_i,
  input  wire [`SND_LEVEL_W-1:0] pulse1_level_i,
  input  wire [`SND_LEVEL_W-1:0] pulse2_level_i,
  input  wire [`SND_LEVEL_W-1:0] noise_level_i,
  output snd_pkg::sample_t       sample_o,
  output logic                   sample_valid_o
);

  logic [`SND_SAMPLE_W-1:0] pulse_sum;
  logic [`SND_SAMPLE_W-1:0] mix;

  // levels are registered in the voices and only move on a tick
  assign pulse_sum = `SND_SAMPLE_W'(pulse1_level_i) + `SND_SAMPLE_W'(pulse2_level_i);
  assign mix = pulse_sum * `SND_SAMPLE_W'(`SND_PULSE_GAIN)
             + `SND_SAMPLE_W'(noise_level_i) * `SND_SAMPLE_W'(`SND_NOISE_GAIN);

  assign sample_o.value = mix;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sample_valid_o <= 1'b0;
    end else begin
      sample_valid_o <= tick_i;
    end
  end

  a_valid_after_tick: assert property (@(posedge clk_i) disable iff (rst_i)
    sample_valid_o |-> $past(tick_i));

endmodule

`default_nettype wire

// File: logic/snd_noise.sv
`timescale 1ns/100ps
`default_nettype none

`include "snd_defs.svh"

module snd_noise (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     tick_i,
  input  snd_pkg::noise_cfg_t     cfg_i,
  output logic [`SND_LEVEL_W-1:0] level_o
);

  logic [6:0]             cnt_q;
  logic [6:0]             cnt_d;
  logic [`SND_LFSR_W-1:0] lfsr_q;
  logic [`SND_LFSR_W-1:0] lfsr_d;
  logic                   fb;

  // short mode taps bit 6
  assign fb = lfsr_q[0] ^ (cfg_i.mode ? lfsr_q[6] : lfsr_q[1]);

  always_comb begin
    cnt_d  = cnt_q;
    lfsr_d = lfsr_q;
    if (!cfg_i.en) begin
      cnt_d  = '0;
      lfsr_d = `SND_LFSR_SEED;
    end else if (cnt_q == '0) begin
      cnt_d  = {cfg_i.period_code, 4'hF};
      lfsr_d = {fb, lfsr_q[`SND_LFSR_W-1:1]};
    end else begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q   <= '0;
      lfsr_q  <= `SND_LFSR_SEED;
      level_o <= '0;
    end else if (tick_i) begin
      cnt_q   <= cnt_d;
      lfsr_q  <= lfsr_d;
      level_o <= (cfg_i.en && lfsr_d[0]) ? cfg_i.vol : '0;
    end
  end

endmodule

`default_nettype wire

// File: logic/snd_pulse.sv
`timescale 1ns/100ps
`default_nettype none

`include "snd_defs.svh"

module snd_pulse (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     tick_i,
  input  snd_pkg::pulse_cfg_t     cfg_i,
  output logic [`SND_LEVEL_W-1:0] level_o
);

  logic [`SND_PERIOD_W-1:0] cnt_q;
  logic [2:0]               idx_q;
  logic [7:0]               pattern;

  // 2A03 duty tables, stepped from bit 7 down
  always_comb begin
    case (cfg_i.duty)
      2'd0: pattern = 8'b1000_0000;
      2'd1: pattern = 8'b1100_0000;
      2'd2: pattern = 8'b1111_0000;
      default: pattern = 8'b0011_1111;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q   <= '0;
      idx_q   <= '0;
      level_o <= '0;
    end else if (tick_i) begin
      if (!cfg_i.en) begin
        cnt_q   <= '0;
        idx_q   <= '0;
        level_o <= '0;
      end else if (cnt_q == '0) begin
        cnt_q   <= cfg_i.period;
        idx_q   <= idx_q - 1'b1;
        level_o <= pattern[idx_q] ? cfg_i.vol : '0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/snd_tick_div.sv
`timescale 1ns/100ps
`default_nettype none

`include "snd_defs.svh"

module snd_tick_div (
  input  wire  clk_i,
  input  wire  rst_i,
  output logic tick_o
);

  logic [`SND_TICK_W-1:0] cnt_q;
  logic                   wrap;

  assign wrap = (cnt_q == `SND_TICK_W'(`SND_TICK_DIV - 1));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      tick_o <= 1'b0;
    end else begin
      cnt_q  <= wrap ? '0 : cnt_q + 1'b1;
      tick_o <= wrap;
    end
  end

  a_tick_single: assert property (@(posedge clk_i) disable iff (rst_i)
    tick_o |=> !tick_o);

endmodule

`default_nettype wire

// File: logic/snd_regfile.sv
`timescale 1ns/100ps
`default_nettype none

`include "snd_defs.svh"

module snd_regfile (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     access_i,
  input  snd_pkg::bus_req_t       access_req_i,
  output logic [`SND_DATA_W-1:0]  rdata_o,
  output snd_pkg::pulse_cfg_t     pulse1_cfg_o,
  output snd_pkg::pulse_cfg_t     pulse2_cfg_o,
  output snd_pkg::noise_cfg_t     noise_cfg_o
);

  logic [`SND_DATA_W-1:0] regs_q [`SND_NUM_REGS];

  function automatic snd_pkg::pulse_cfg_t decode_pulse(
    input logic                   en,
    input logic [`SND_DATA_W-1:0] ctrl,
    input logic [`SND_DATA_W-1:0] lo,
    input logic [`SND_DATA_W-1:0] hi
  );
    snd_pkg::pulse_cfg_t cfg;
    cfg.en     = en;
    cfg.duty   = ctrl[7:6];
    cfg.vol    = ctrl[3:0];
    cfg.period = {hi[2:0], lo};
    return cfg;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `SND_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (access_i && access_req_i.wr) begin
      regs_q[access_req_i.addr] <= access_req_i.wdata;
    end
  end

  // read data held until the next read
  always_ff @(posedge clk_i) begin
    if (access_i && !access_req_i.wr) begin
      rdata_o <= regs_q[access_req_i.addr];
    end
  end

  assign pulse1_cfg_o = decode_pulse(regs_q[7][0], regs_q[0], regs_q[1], regs_q[2]);
  assign pulse2_cfg_o = decode_pulse(regs_q[7][1], regs_q[3], regs_q[4], regs_q[5]);

  assign noise_cfg_o.en          = regs_q[7][2];
  assign noise_cfg_o.mode        = regs_q[6][7];
  assign noise_cfg_o.period_code = regs_q[6][6:4];
  assign noise_cfg_o.vol         = regs_q[6][3:0];

endmodule

`default_nettype wire

// File: logic/snd_bus_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module snd_bus_ctrl (
  input  wire               clk_i,
  input  wire               rst_i,
  input  wire               req_i,
  input  snd_pkg::bus_req_t host_req_i,
  output logic              ack_o,
  output logic              access_o,
  output snd_pkg::bus_req_t access_req_o
);

  snd_pkg::bus_state_e state_q;
  snd_pkg::bus_state_e state_d;
  snd_pkg::bus_req_t   req_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      snd_pkg::IDLE: begin
        if (req_i) begin
          state_d = snd_pkg::ACCESS;
        end
      end
      snd_pkg::ACCESS: begin
        state_d = snd_pkg::HOLD_ACK;
      end
      snd_pkg::HOLD_ACK: begin
        // wait for host to drop req
        if (!req_i) begin
          state_d = snd_pkg::IDLE;
        end
      end
      default: begin
        state_d = snd_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= snd_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // request fields sampled as the handshake opens
  always_ff @(posedge clk_i) begin
    if (state_q == snd_pkg::IDLE && req_i) begin
      req_q <= host_req_i;
    end
  end

  assign access_o     = (state_q == snd_pkg::ACCESS);
  assign access_req_o = req_q;
  assign ack_o        = (state_q == snd_pkg::HOLD_ACK);

  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(ack_o) |-> req_i);

  // host keeps req and the same fields up through the access
  a_access_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    access_o |-> (req_i && host_req_i == access_req_o));

endmodule

`default_nettype wire

// File: logic/snd_pkg.sv
`default_nettype none

`include "snd_defs.svh"

package snd_pkg;

  // one host access
  typedef struct packed {
    logic                   wr;
    logic [`SND_ADDR_W-1:0] addr;
    logic [`SND_DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic                     en;
    logic [1:0]               duty;
    logic [`SND_LEVEL_W-1:0]  vol;
    logic [`SND_PERIOD_W-1:0] period;
  } pulse_cfg_t;

  typedef struct packed {
    logic                    en;
    // 1 selects the short sequence
    logic                    mode;
    logic [2:0]              period_code;
    logic [`SND_LEVEL_W-1:0] vol;
  } noise_cfg_t;

  typedef struct packed {
    logic [`SND_SAMPLE_W-1:0] value;
  } sample_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    HOLD_ACK
  } bus_state_e;

endpackage

`default_nettype wire

// File: logic/snd_defs.svh
`ifndef SND_DEFS_SVH
`define SND_DEFS_SVH

// sound tick every 4 clk_i cycles
`define SND_TICK_DIV 4
`define SND_TICK_W 3

// register file
`define SND_NUM_REGS 8
`define SND_ADDR_W 3
`define SND_DATA_W 8

// voices and mix
`define SND_LEVEL_W 4
`define SND_PERIOD_W 11
`define SND_LFSR_W 15
`define SND_LFSR_SEED 15'h0001
`define SND_PULSE_GAIN 64
`define SND_NOISE_GAIN 48
`define SND_SAMPLE_W 16

`endif
